//--- Bender.yml
package:
  name: exerionVideo

sources:
  - include_dirs:
      - logic
    files:
      - logic/exerionVideoTimingPkg.sv
      - logic/exerionVideoPixelPkg.sv
      - logic/spriteWriteIf.sv
      - logic/rasterTimer.sv
      - logic/spriteRowDrawer.sv
      - logic/spriteLineBuffer.sv
      - logic/layerPriorityMixer.sv
      - logic/exerionVideo.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/exerionVideo_checker.sv
      - bench/exerionVideoTb.sv

//--- bench/exerionVideoTb.sv
// runs two frames after reset with LFSR stimulus; host keeps requests to H <= 480 and X in 88..504
`include "exerionVideo_macros.svh"

module exerionVideoTb;

	localparam int HALF_PERIOD = 2;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 16;
	localparam int LINE_CYCLES = `EXV_H_LAST - `EXV_H_FIRST + 1;
	localparam int FRAME_CYCLES = LINE_CYCLES * 256;
	localparam int RUN_CYCLES = 2 * FRAME_CYCLES;
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + RESET_CYCLES;
	localparam int REQ_H_LIMIT = 480;
	localparam int X_SPAN = 504 - `EXV_H_FIRST + 1;
	localparam logic [8:0] RESET_OUT = 9'b00000_1_1_0_0;   // index, hb, vb, hs, vs

	logic clk2_6MHZ;
	logic RAMB;
	logic [3:0] fgPix, bgPix;
	logic spriteReq;
	logic [8:0] spriteX;
	logic [31:0] spriteStrip;
	logic spriteBusy;
	logic [8:0] pixelH;
	logic [7:0] pixelV;
	logic [4:0] colorIndex;
	logic hBlank, vBlank, hSync, vSync;

	logic [31:0] lfsrState = 32'hc233_71f8;
	int cycleCount = 0;
	int cyclesChecked = 0;

	// model state
	logic [3:0] modelBuf [0:1][0:511];
	logic [8:0] modelH;
	logic [7:0] modelV;
	int busyLeft;
	logic [8:0] histH [0:1];
	logic [7:0] histV [0:1];
	logic [3:0] histFg [0:1];
	logic [3:0] histBg [0:1];
	logic [3:0] histSp [0:1];
	logic [1:0] histValid;

	exerionVideo u_exerionVideo (
		.clk2_6MHZ     (clk2_6MHZ),
		.RAMB          (RAMB),
		.fgPix_i       (fgPix),
		.bgPix_i       (bgPix),
		.spriteReq_i   (spriteReq),
		.spriteX_i     (spriteX),
		.spriteStrip_i (spriteStrip),
		.spriteBusy_o  (spriteBusy),
		.pixelH_o      (pixelH),
		.pixelV_o      (pixelV),
		.colorIndex_o  (colorIndex),
		.hBlank_o      (hBlank),
		.vBlank_o      (vBlank),
		.hSync_o       (hSync),
		.vSync_o       (vSync)
	);

	always #HALF_PERIOD clk2_6MHZ = ~clk2_6MHZ;

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
	endfunction

	task automatic takeBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic compareValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %0h actual %0h", testName, expected, actual);
			$display("Test FAILED");
			$fatal(1, "value mismatch in %s", testName);
		end
	endtask

	// expected {index, hBlank, vBlank, hSync, vSync} for one raster position
	function automatic logic [8:0] expectedOutput(input logic [8:0] h, input logic [7:0] v,
			input logic [3:0] fg, input logic [3:0] bg, input logic [3:0] sp);
		logic hb, vb, hs, vs;
		logic [4:0] idx;
		hb = (h < `EXV_HBLANK_LOW) || (h > `EXV_HBLANK_HIGH);
		vb = (v < `EXV_VBLANK_LOW) || (v > `EXV_VBLANK_HIGH);
		hs = (h >= `EXV_HSYNC_FIRST) && (h <= `EXV_HSYNC_LAST);
		vs = !((v >= `EXV_VSYNC_FIRST) && (v <= `EXV_VSYNC_LAST));   // low pulse
		if (hb || vb)
			idx = '0;
		else if (fg != '0)
			idx = {1'b1, fg};
		else if (sp != '0)
			idx = {1'b1, sp};
		else
			idx = {1'b0, bg};
		return {idx, hb, vb, hs, vs};
	endfunction

	// ========================================
	// stimulus
	// ========================================
	initial begin : driveProc
		logic [31:0] bits;
		@(posedge RAMB);
		forever begin
			@(posedge clk2_6MHZ);
			#DRIVE_DELAY;
			takeBits(5, bits);
			fgPix = bits[4] ? bits[3:0] : 4'h0;    // about half transparent
			takeBits(5, bits);
			bgPix = bits[4] ? bits[3:0] : 4'h0;
			spriteReq = 1'b0;
			if (pixelH <= REQ_H_LIMIT) begin
				takeBits(3, bits);
				if (bits[2:0] == 3'd0) begin    // also lands while busy now and then
					spriteReq = 1'b1;
					takeBits(9, bits);
					spriteX = 9'(`EXV_H_FIRST + bits % X_SPAN);
					for (int k = 0; k < `EXV_STRIP_WIDTH; k++) begin
						takeBits(5, bits);
						spriteStrip[4*k +: 4] = bits[4] ? bits[3:0] : 4'h0;
					end
				end
			end
		end
	end

	// ========================================
	// reference model and comparison
	// ========================================
	initial begin : compareProc
		logic [8:0] expOut;
		logic [3:0] spPix;
		logic [3:0] stripPix;
		string posTag;
		for (int a = 0; a < 512; a++) begin
			modelBuf[0][a] = '0;
			modelBuf[1][a] = '0;
		end
		modelH = `EXV_H_FIRST;
		modelV = '0;
		busyLeft = 0;
		histValid = 2'b00;
		@(posedge RAMB);
		forever begin
			@(negedge clk2_6MHZ);
			compareValue("pixelH", modelH, pixelH);
			compareValue("pixelV", modelV, pixelV);
			compareValue("spriteBusy", busyLeft != 0, spriteBusy);
			if (histValid[1]) begin
				expOut = expectedOutput(histH[1], histV[1], histFg[1], histBg[1], histSp[1]);
				posTag = $sformatf("H=%0d V=%0d", histH[1], histV[1]);
			end else begin
				expOut = RESET_OUT;
				posTag = "after reset";
			end
			compareValue({"colorIndex ", posTag}, expOut[8:4], colorIndex);
			compareValue({"hBlank ", posTag}, expOut[3], hBlank);
			compareValue({"vBlank ", posTag}, expOut[2], vBlank);
			compareValue({"hSync ", posTag}, expOut[1], hSync);
			compareValue({"vSync ", posTag}, expOut[0], vSync);

			spPix = modelBuf[modelV[0]][modelH];    // shown, then erased
			modelBuf[modelV[0]][modelH] = '0;

			// an accepted strip lands in the buffer of the next line
			if (busyLeft != 0) begin
				busyLeft--;
			end else if (spriteReq) begin
				for (int k = 0; k < `EXV_STRIP_WIDTH; k++) begin
					stripPix = spriteStrip[4*k +: 4];
					if (stripPix != '0)
						modelBuf[!modelV[0]][spriteX + k] = stripPix;
				end
				busyLeft = `EXV_STRIP_WIDTH;
			end

			histH[1] = histH[0];
			histV[1] = histV[0];
			histFg[1] = histFg[0];
			histBg[1] = histBg[0];
			histSp[1] = histSp[0];
			histValid = {histValid[0], 1'b1};
			histH[0] = modelH;
			histV[0] = modelV;
			histFg[0] = fgPix;
			histBg[0] = bgPix;
			histSp[0] = spPix;

			if (modelH == `EXV_H_LAST) begin
				modelH = `EXV_H_FIRST;
				modelV = modelV + 1'b1;
			end else begin
				modelH = modelH + 1'b1;
			end
			cyclesChecked++;
		end
	end

	// ========================================
	// run control
	// ========================================
	always @(posedge clk2_6MHZ) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(u_exerionVideo.u_checker.assertFails) begin
		if (u_exerionVideo.u_checker.assertFails != 0) begin
			$display("an assertion in the bound checker failed");
			$display("Test FAILED");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		clk2_6MHZ = 1'b0;
		RAMB = 1'b0;
		fgPix = '0;
		bgPix = '0;
		spriteReq = 1'b0;
		spriteX = `EXV_H_FIRST;
		spriteStrip = '0;
		repeat (RESET_CYCLES) @(posedge clk2_6MHZ);
		#DRIVE_DELAY;
		RAMB = 1'b1;
		wait (cyclesChecked >= RUN_CYCLES);
		if (u_exerionVideo.u_checker.assertFails == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("Test FAILED");
			$fatal(1, "assertion failures at end of run");
		end
	end

endmodule

//--- bench/exerionVideo_checker.sv
// bound to exerionVideo; properties are disabled while RAMB is low, failures only raise $error
`include "exerionVideo_macros.svh"

module exerionVideo_checker (
	input logic clk2_6MHZ,
	input logic RAMB,
	input logic busy_i,
	input logic [8:0] pixelH_i,
	input logic [4:0] colorIndex_i,
	input logic hBlank_i,
	input logic vBlank_i
);

	int assertFails = 0;    // read by the testbench

	// ========================================
	// sprite drawer
	// ========================================
	busyLength: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		$rose(busy_i) |-> busy_i [*`EXV_STRIP_WIDTH] ##1 !busy_i)
	else begin
		$error("sprite busy did not stay high for exactly %0d cycles", `EXV_STRIP_WIDTH);
		assertFails++;
	end

	// ========================================
	// mixer and raster
	// ========================================
	blankIsBlack: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		(hBlank_i || vBlank_i) |-> (colorIndex_i == '0))
	else begin
		$error("palette index is not zero during blanking");
		assertFails++;
	end

	hCountRange: assert property (@(posedge clk2_6MHZ) disable iff (!RAMB)
		(pixelH_i >= `EXV_H_FIRST) && (pixelH_i <= `EXV_H_LAST))
	else begin
		$error("horizontal count left the range %0d to %0d", `EXV_H_FIRST, `EXV_H_LAST);
		assertFails++;
	end

endmodule

bind exerionVideo exerionVideo_checker u_checker (
	.clk2_6MHZ    (clk2_6MHZ),
	.RAMB         (RAMB),
	.busy_i       (spriteBusy_o),
	.pixelH_i     (pixelH_o),
	.colorIndex_i (colorIndex_o),
	.hBlank_i     (hBlank_o),
	.vBlank_i     (vBlank_o)
);

//--- exerionVideo.f
+incdir+logic
logic/exerionVideoTimingPkg.sv
logic/exerionVideoPixelPkg.sv
logic/spriteWriteIf.sv
logic/rasterTimer.sv
logic/spriteRowDrawer.sv
logic/spriteLineBuffer.sv
logic/layerPriorityMixer.sv
logic/exerionVideo.sv
bench/exerionVideo_checker.sv
bench/exerionVideoTb.sv

//--- logic/exerionVideo.sv
// video core top; outputs a palette index two clocks after the position on pixelH_o and pixelV_o
module exerionVideo (
	input  logic clk2_6MHZ,
	input  logic RAMB,
	input  logic [3:0] fgPix_i,
	input  logic [3:0] bgPix_i,
	input  logic spriteReq_i,
	input  logic [8:0] spriteX_i,
	input  logic [31:0] spriteStrip_i,
	output logic spriteBusy_o,
	output logic [8:0] pixelH_o,
	output logic [7:0] pixelV_o,
	output logic [4:0] colorIndex_o,
	output logic hBlank_o,
	output logic vBlank_o,
	output logic hSync_o,
	output logic vSync_o
);

	exerionVideoTimingPkg::hCount_t hCount;
	exerionVideoTimingPkg::vCount_t vCount;
	exerionVideoPixelPkg::pixel_t spritePix;

	spriteWriteIf spriteWr ();   // drawer to line buffers

	rasterTimer u_rasterTimer (
		.clk2_6MHZ (clk2_6MHZ),
		.RAMB      (RAMB),
		.hCount_o  (hCount),
		.vCount_o  (vCount)
	);

	// ========================================
	// sprite path
	// ========================================
	spriteRowDrawer u_spriteRowDrawer (
		.clk2_6MHZ     (clk2_6MHZ),
		.RAMB          (RAMB),
		.spriteReq_i   (spriteReq_i),
		.spriteX_i     (spriteX_i),
		.spriteStrip_i (spriteStrip_i),
		.lineParity_i  (vCount[0]),
		.busy_o        (spriteBusy_o),
		.wr            (spriteWr.drawer)
	);

	spriteLineBuffer u_spriteLineBuffer (
		.clk2_6MHZ    (clk2_6MHZ),
		.wr           (spriteWr.buffer),
		.hCount_i     (hCount),
		.lineParity_i (vCount[0]),   // display the buffer of this line
		.spritePix_o  (spritePix)
	);

	layerPriorityMixer u_layerPriorityMixer (
		.clk2_6MHZ    (clk2_6MHZ),
		.RAMB         (RAMB),
		.hCount_i     (hCount),
		.vCount_i     (vCount),
		.fgPix_i      (fgPix_i),
		.bgPix_i      (bgPix_i),
		.spritePix_i  (spritePix),
		.colorIndex_o (colorIndex_o),
		.hBlank_o     (hBlank_o),
		.vBlank_o     (vBlank_o),
		.hSync_o      (hSync_o),
		.vSync_o      (vSync_o)
	);

	assign pixelH_o = hCount;
	assign pixelV_o = vCount;

endmodule

//--- logic/exerionVideoPixelPkg.sv
// pixel types; a zero layer code is transparent, so colour 0 of a layer can never be shown
`include "exerionVideo_macros.svh"

package exerionVideoPixelPkg;

	// 4-bit colour code of one layer
	typedef logic [3:0] pixel_t;

	// palette index, top bit selects the bright half
	typedef logic [4:0] colorIndex_t;

	// one strip of sprite colour, pixel 0 in the lowest nibble
	typedef pixel_t [`EXV_STRIP_WIDTH-1:0] spriteStrip_t;

	// strip drawer FSM
	typedef enum logic {
		IDLE = 1'b0,
		DRAW = 1'b1
	} drawState_t;

endpackage

//--- logic/exerionVideoTimingPkg.sv
// raster position types; the horizontal count only ever holds 88 to 511 in normal running
package exerionVideoTimingPkg;

	// horizontal position, also the line buffer address
	typedef logic [8:0] hCount_t;

	// line number, bit 0 picks the sprite line buffer
	typedef logic [7:0] vCount_t;

endpackage

//--- logic/exerionVideo_macros.svh
// raster bounds assume one pixel per clk2_6MHZ; blank and sync windows are inclusive limits
`ifndef EXERION_VIDEO_MACROS_SVH
`define EXERION_VIDEO_MACROS_SVH

// ========================================
// raster counter limits
// ========================================
`define EXV_H_FIRST 88      // first horizontal count after the wrap
`define EXV_H_LAST 511      // last horizontal count of a line

// ========================================
// blanking windows
// ========================================
// horizontal blank while the count is below LOW or above HIGH
`define EXV_HBLANK_LOW 90
`define EXV_HBLANK_HIGH 437
// vertical blank while the line is below LOW or above HIGH
`define EXV_VBLANK_LOW 16
`define EXV_VBLANK_HIGH 239

// ========================================
// sync windows
// ========================================
`define EXV_HSYNC_FIRST 432 // hsync is high inside this window
`define EXV_HSYNC_LAST 447
`define EXV_VSYNC_FIRST 248 // vsync is low inside this window
`define EXV_VSYNC_LAST 251

// sprite strips are drawn this many pixels at a time
`define EXV_STRIP_WIDTH 8

`endif

//--- logic/layerPriorityMixer.sv
// two-stage mixer; spritePix_i must already be one clock behind the counts, as the buffer gives it
`include "exerionVideo_macros.svh"

module layerPriorityMixer (
	input  logic clk2_6MHZ,
	input  logic RAMB,
	input  exerionVideoTimingPkg::hCount_t hCount_i,
	input  exerionVideoTimingPkg::vCount_t vCount_i,
	input  exerionVideoPixelPkg::pixel_t fgPix_i,
	input  exerionVideoPixelPkg::pixel_t bgPix_i,
	input  exerionVideoPixelPkg::pixel_t spritePix_i,
	output exerionVideoPixelPkg::colorIndex_t colorIndex_o,
	output logic hBlank_o,
	output logic vBlank_o,
	output logic hSync_o,
	output logic vSync_o
);

	exerionVideoPixelPkg::pixel_t fgS1, bgS1;
	logic hBlankS1, vBlankS1, hSyncS1, vSyncS1;

	// ========================================
	// stage one, flags decoded from the counts
	// ========================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			hBlankS1 <= 1'b1;
			vBlankS1 <= 1'b1;
			hSyncS1 <= 1'b0;
			vSyncS1 <= 1'b0;
		end else begin
			hBlankS1 <= (hCount_i < `EXV_HBLANK_LOW) || (hCount_i > `EXV_HBLANK_HIGH);
			vBlankS1 <= (vCount_i < `EXV_VBLANK_LOW) || (vCount_i > `EXV_VBLANK_HIGH);
			hSyncS1 <= (hCount_i >= `EXV_HSYNC_FIRST) && (hCount_i <= `EXV_HSYNC_LAST);
			vSyncS1 <= !((vCount_i >= `EXV_VSYNC_FIRST) && (vCount_i <= `EXV_VSYNC_LAST));
		end
	end

	// layer pixels for the same position
	always_ff @(posedge clk2_6MHZ) begin
		fgS1 <= fgPix_i;
		bgS1 <= bgPix_i;
	end

	// ========================================
	// stage two, priority fg > sprite > bg
	// ========================================
	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			colorIndex_o <= '0;
			hBlank_o <= 1'b1;
			vBlank_o <= 1'b1;
			hSync_o <= 1'b0;
			vSync_o <= 1'b0;
		end else begin
			if (hBlankS1 || vBlankS1) colorIndex_o <= '0;
			else if (fgS1 != '0) colorIndex_o <= {1'b1, fgS1};        // bright half
			else if (spritePix_i != '0) colorIndex_o <= {1'b1, spritePix_i};
			else colorIndex_o <= {1'b0, bgS1};                        // dark half
			hBlank_o <= hBlankS1;
			vBlank_o <= vBlankS1;
			hSync_o <= hSyncS1;
			vSync_o <= vSyncS1;
		end
	end

endmodule

//--- logic/rasterTimer.sv
// raster counter; horizontal runs 88 to 511 and the 8-bit line count wraps freely from 255 to 0
`include "exerionVideo_macros.svh"

module rasterTimer (
	input  logic clk2_6MHZ,
	input  logic RAMB,
	output exerionVideoTimingPkg::hCount_t hCount_o,
	output exerionVideoTimingPkg::vCount_t vCount_o
);

	// ========================================
	// position registers
	// ========================================
	exerionVideoTimingPkg::hCount_t hCount;
	exerionVideoTimingPkg::vCount_t vCount;

	logic lineEnd;

	// last pixel of the line
	assign lineEnd = (hCount == exerionVideoTimingPkg::hCount_t'(`EXV_H_LAST));

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			hCount <= exerionVideoTimingPkg::hCount_t'(`EXV_H_FIRST);
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= exerionVideoTimingPkg::hCount_t'(`EXV_H_FIRST); // skip 0 to 87
			vCount <= vCount + 1'b1;   // 255 rolls over to 0
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// the rest of the design sees the counter directly
	assign hCount_o = hCount;
	assign vCount_o = vCount;

endmodule

//--- logic/spriteLineBuffer.sv
// alternating line buffers; the drawer must never target the buffer of the line being shown
module spriteLineBuffer (
	input  logic clk2_6MHZ,
	spriteWriteIf.buffer wr,
	input  exerionVideoTimingPkg::hCount_t hCount_i,
	input  logic lineParity_i,
	output exerionVideoPixelPkg::pixel_t spritePix_o
);

	// one entry for every horizontal count, 0 to 87 simply stay unused
	localparam int LINE_DEPTH = 2 ** $bits(exerionVideoTimingPkg::hCount_t);

	// ========================================
	// storage
	// ========================================
	// index 0 serves even lines, index 1 odd lines
	exerionVideoPixelPkg::pixel_t lineMem [0:1][0:LINE_DEPTH-1];

	// display side
	// the pixel under the beam is read and then erased so the buffer is
	// empty again by the time the drawer fills it for line V+2
	always_ff @(posedge clk2_6MHZ) begin
		spritePix_o <= lineMem[lineParity_i][hCount_i];   // valid one clock later
		lineMem[lineParity_i][hCount_i] <= '0;
		if (wr.wrEn) begin
			lineMem[wr.wrSel][wr.wrAddr] <= wr.wrData;    // other buffer
		end
	end

endmodule

//--- logic/spriteRowDrawer.sv
// strip drawer; requests while busy are dropped and the host keeps X+7 inside the visible line
`include "exerionVideo_macros.svh"

module spriteRowDrawer (
	input  logic clk2_6MHZ,
	input  logic RAMB,
	input  logic spriteReq_i,
	input  exerionVideoTimingPkg::hCount_t spriteX_i,
	input  exerionVideoPixelPkg::spriteStrip_t spriteStrip_i,
	input  logic lineParity_i,
	output logic busy_o,
	spriteWriteIf.drawer wr
);

	localparam int CNT_W = $clog2(`EXV_STRIP_WIDTH);
	localparam int STRIP_LAST = `EXV_STRIP_WIDTH - 1;

	// ========================================
	// control state
	// ========================================
	exerionVideoPixelPkg::drawState_t drawState;
	logic [CNT_W-1:0] stripCnt;     // pixel being written

	// latched request
	exerionVideoPixelPkg::spriteStrip_t stripReg;
	exerionVideoTimingPkg::hCount_t xBase;
	logic wrSelReg;

	exerionVideoPixelPkg::pixel_t curPix;
	logic accept;

	assign accept = spriteReq_i && (drawState == exerionVideoPixelPkg::IDLE);

	always_ff @(posedge clk2_6MHZ or negedge RAMB) begin
		if (!RAMB) begin
			drawState <= exerionVideoPixelPkg::IDLE;
			stripCnt <= '0;
		end else begin
			case (drawState)
				exerionVideoPixelPkg::IDLE: begin
					stripCnt <= '0;
					if (accept) begin
						drawState <= exerionVideoPixelPkg::DRAW;
					end
				end
				exerionVideoPixelPkg::DRAW: begin
					stripCnt <= stripCnt + 1'b1;
					if (stripCnt == CNT_W'(STRIP_LAST)) begin
						drawState <= exerionVideoPixelPkg::IDLE; // eighth pixel done
					end
				end
				default: drawState <= exerionVideoPixelPkg::IDLE;
			endcase
		end
	end

	// strip, start and target buffer are captured on acceptance
	always_ff @(posedge clk2_6MHZ) begin
		if (accept) begin
			stripReg <= spriteStrip_i;
			xBase <= spriteX_i;
			wrSelReg <= ~lineParity_i;  // draw into the buffer of the next line
		end
	end

	// ========================================
	// write port
	// ========================================
	assign curPix = stripReg[stripCnt];

	// transparent pixels leave whatever is already in the buffer
	assign wr.wrEn = (drawState == exerionVideoPixelPkg::DRAW) && (curPix != '0);
	assign wr.wrSel = wrSelReg;
	assign wr.wrAddr = xBase + exerionVideoTimingPkg::hCount_t'(stripCnt);
	assign wr.wrData = curPix;

	assign busy_o = (drawState == exerionVideoPixelPkg::DRAW);

endmodule

//--- logic/spriteWriteIf.sv
// line buffer write port; no acknowledge, so each clock with wrEn high is one committed write
interface spriteWriteIf;

	logic wrEn;                                  // write strobe, one pixel per clock
	logic wrSel;                                 // which of the two line buffers
	exerionVideoTimingPkg::hCount_t wrAddr;      // horizontal position of the pixel
	exerionVideoPixelPkg::pixel_t wrData;        // nonzero sprite colour

	modport drawer (
		output wrEn,
		output wrSel,
		output wrAddr,
		output wrData
	);

	modport buffer (
		input wrEn,
		input wrSel,
		input wrAddr,
		input wrData
	);

endinterface
